/* include/xc_consts.svh */
/*
 * Sizing constants for the correlator. The pair count must match
 * n*(n-1)/2 for the line count. The bit period is in clocks, kept short for simulation.
 */
`ifndef XC_CONSTS_SVH
`define XC_CONSTS_SVH

`define XC_NUM_LINES 4      // Input lines.
`define XC_COUNT_W 16       // Counter width, two bytes on readout.
`define XC_NUM_PAIRS 6      // Line pairs, i<j.
`define XC_NUM_COUNTERS 10  // Auto counters plus pair counters.

// Clocks per serial bit.
`define XC_BIT_CLKS 16

`endif

/* hdl/xc_ctrl_pkg.sv */
/*
 * Control types for the command decoder and readout sequencer.
 * Opcodes are ASCII command bytes. rd_index spans all counters.
 */
`default_nettype none

`include "xc_consts.svh"

package xc_ctrl_pkg;

	// Controller FSM states.
	typedef enum logic [2:0] {
		IDLE    = 3'd0,  // Counting, waiting for commands.
		LOAD    = 3'd1,  // Latch selected counter.
		SEND_HI = 3'd2,
		SEND_LO = 3'd3,
		WAIT    = 3'd4   // Frame in flight.
	} ctrl_state_e;

	// Command bytes on the serial link.
	typedef enum logic [7:0] {
		OP_CLEAR = 8'h43,  // 'C'.
		OP_READ  = 8'h52   // 'R'.
	} opcode_e;

	typedef struct packed {
		logic clear;                                    // One-cycle pulse.
		logic accumulate;                               // Level.
		logic [$clog2(`XC_NUM_COUNTERS)-1:0] rd_index;  // Readout select.
	} corr_ctrl_t;

	typedef struct packed {
		logic       start;  // Only while busy is low.
		logic [7:0] data;
	} tx_req_t;

endpackage

`default_nettype wire

/* hdl/xc_data_pkg.sv */
/*
 * Data types moving between sampler, correlator and receiver.
 * Widths follow the constants header.
 */
`default_nettype none

`include "xc_consts.svh"

package xc_data_pkg;

	// One accepted sample. Lines are valid with the strobe.
	typedef struct packed {
		logic                     strobe;
		logic [`XC_NUM_LINES-1:0] lines;
	} sample_t;

	// Counter value, saturating.
	typedef logic [`XC_COUNT_W-1:0] count_t;

	// Received byte, valid for one cycle.
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} rx_byte_t;

endpackage

`default_nettype wire

/* hdl/xc_sampler.sv */
/*
 * Lines and strobe are asynchronous. Output strobe appears three clocks
 * after the sample rising edge. Lines must be stable around that edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "xc_consts.svh"

module xc_sampler (
	input  logic                     clki,
	input  logic                     arst_n,
	input  logic [`XC_NUM_LINES-1:0] line_in,
	input  logic                     sample,
	output xc_data_pkg::sample_t     smp
);

	logic [`XC_NUM_LINES-1:0] line_s1, line_s2;  // Line synchronizer.
	logic                     smp_s1, smp_s2;    // Strobe synchronizer.
	logic                     smp_q;             // Previous synced strobe.

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			line_s1 <= '0;
			line_s2 <= '0;
			smp_s1 <= 1'b0;
			smp_s2 <= 1'b0;
			smp_q <= 1'b0;
			smp <= '0;
		end else begin
			line_s1 <= line_in;  // Lines take the same stages as the strobe.
			line_s2 <= line_s1;
			smp_s1 <= sample;
			smp_s2 <= smp_s1;
			smp_q <= smp_s2;
			smp.lines <= line_s2;
			smp.strobe <= smp_s2 & ~smp_q;  // Rising edge only.
		end
	end

endmodule

`default_nettype wire

/* hdl/xc_correlator.sv */
/*
 * Auto counts for each line, then coincidence counts for pairs i<j in
 * lexical order. Counters stop at all ones. Clear beats a sample.
 * Out-of-range rd_index reads zero.
 */
`timescale 1ns/1ps
`default_nettype none

`include "xc_consts.svh"

module xc_correlator (
	input  logic                    clki,
	input  logic                    arst_n,
	input  xc_data_pkg::sample_t    smp,
	input  xc_ctrl_pkg::corr_ctrl_t ctrl,
	output xc_data_pkg::count_t     rd_data
);

	logic [`XC_NUM_PAIRS-1:0]    pair_hit;  // Both lines of a pair high.
	logic [`XC_NUM_COUNTERS-1:0] hit;       // Increment request per counter.
	xc_data_pkg::count_t         cnt [`XC_NUM_COUNTERS];

	// Pair table. Index of (i,j) follows the published order.
	genvar gi, gj;
	generate
		for (gi = 0; gi < `XC_NUM_LINES; gi++) begin : g_line_a
			for (gj = gi + 1; gj < `XC_NUM_LINES; gj++) begin : g_line_b
				localparam int pidx = gi * (2 * `XC_NUM_LINES - gi - 1) / 2 + (gj - gi - 1);
				assign pair_hit[pidx] = smp.lines[gi] & smp.lines[gj];
			end
		end
	endgenerate

	// Autos first, pairs after.
	assign hit = {pair_hit, smp.lines};

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < `XC_NUM_COUNTERS; k++) begin
				cnt[k] <= '0;
			end
		end else if (ctrl.clear) begin
			for (int k = 0; k < `XC_NUM_COUNTERS; k++) begin
				cnt[k] <= '0;  // Wins over a same-cycle sample.
			end
		end else if (smp.strobe && ctrl.accumulate) begin
			for (int k = 0; k < `XC_NUM_COUNTERS; k++) begin
				// Saturate at all ones.
				if (hit[k] && (cnt[k] != '1)) begin
					cnt[k] <= cnt[k] + 1'b1;
				end
			end
		end
	end

	// Readout mux, combinational on rd_index.
	always_comb begin
		rd_data = '0;
		if (ctrl.rd_index < `XC_NUM_COUNTERS) begin
			rd_data = cnt[ctrl.rd_index];
		end
	end

endmodule

`default_nettype wire

/* hdl/xc_uart_rx.sv */
/*
 * 8N1 receiver, LSB first, XC_BIT_CLKS clocks per bit.
 * A frame with a low stop bit is discarded without a strobe.
 */
`timescale 1ns/1ps
`default_nettype none

`include "xc_consts.svh"

module xc_uart_rx (
	input  logic                  clki,
	input  logic                  arst_n,
	input  logic                  rx,
	output xc_data_pkg::rx_byte_t rx_byte
);

	localparam int cnt_w = $clog2(`XC_BIT_CLKS);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e        state;
	logic             rx_s1, rx_s2;  // Synchronizer, idles high.
	logic [cnt_w-1:0] clk_cnt;       // Clocks within a bit.
	logic [2:0]       bit_cnt;       // Data bit number.

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_byte <= '0;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
			rx_byte.valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx_s2) state <= RX_START;  // Falling edge of start.
				end
				RX_START: if (clk_cnt == cnt_w'(`XC_BIT_CLKS / 2 - 1)) begin
					clk_cnt <= '0;  // Now at the start bit center.
					bit_cnt <= '0;
					state <= rx_s2 ? RX_IDLE : RX_DATA;  // Glitch goes back.
				end
				RX_DATA: if (clk_cnt == cnt_w'(`XC_BIT_CLKS - 1)) begin
					rx_byte.data <= {rx_s2, rx_byte.data[7:1]};  // LSB first.
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7) state <= RX_STOP;
				end
				RX_STOP: if (clk_cnt == cnt_w'(`XC_BIT_CLKS - 1)) begin
					rx_byte.valid <= rx_s2;  // Framing check.
					state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/xc_uart_tx.sv */
/*
 * 8N1 transmitter, LSB first. A start request is only taken while
 * busy is low. busy covers start, data and stop bits.
 */
`timescale 1ns/1ps
`default_nettype none

`include "xc_consts.svh"

module xc_uart_tx (
	input  logic                 clki,
	input  logic                 arst_n,
	input  xc_ctrl_pkg::tx_req_t req,
	output logic                 tx,
	output logic                 busy
);

	localparam int cnt_w = $clog2(`XC_BIT_CLKS);

	logic [9:0]       frame;    // {stop, data, start}, shifts right.
	logic [cnt_w-1:0] clk_cnt;  // Clocks within a bit.
	logic [3:0]       bit_cnt;  // Bits sent in this frame.

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			frame <= '1;  // Line idles high.
			busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (req.start) begin
				frame <= {1'b1, req.data, 1'b0};
				busy <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == cnt_w'(`XC_BIT_CLKS - 1)) begin
			clk_cnt <= '0;
			frame <= {1'b1, frame[9:1]};  // Refill with idle level.
			if (bit_cnt == 4'd9) busy <= 1'b0;  // Stop bit done.
			else bit_cnt <= bit_cnt + 1'b1;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	assign tx = frame[0];  // Straight from a flop.

endmodule

`default_nettype wire

/* hdl/xc_control.sv */
/*
 * Command decoder and readout sequencer. Bytes outside IDLE are lost.
 * A read sends every counter MSB first. Counting pauses until the
 * FSM is back in IDLE.
 */
`timescale 1ns/1ps
`default_nettype none

`include "xc_consts.svh"

module xc_control (
	input  logic                    clki,
	input  logic                    arst_n,
	input  logic                    enable,
	input  xc_data_pkg::rx_byte_t   rx_byte,
	input  logic                    busy,
	input  xc_data_pkg::count_t     rd_data,
	output xc_ctrl_pkg::corr_ctrl_t ctrl,
	output xc_ctrl_pkg::tx_req_t    tx_req
);

	localparam int idx_w = $clog2(`XC_NUM_COUNTERS);

	xc_ctrl_pkg::ctrl_state_e state;
	logic [idx_w-1:0]         idx;      // Counter being read out.
	xc_data_pkg::count_t      word;     // Latched counter value.
	logic                     lo_sent;  // Low byte of word is out.
	logic                     clear_q;

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			state <= xc_ctrl_pkg::IDLE;
			idx <= '0;
			word <= '0;
			lo_sent <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			clear_q <= 1'b0;
			case (state)
				xc_ctrl_pkg::IDLE: if (rx_byte.valid) begin
					case (xc_ctrl_pkg::opcode_e'(rx_byte.data))
						xc_ctrl_pkg::OP_CLEAR: clear_q <= 1'b1;
						xc_ctrl_pkg::OP_READ: begin
							idx <= '0;
							state <= xc_ctrl_pkg::LOAD;
						end
						default: ;  // Unknown bytes ignored.
					endcase
				end
				xc_ctrl_pkg::LOAD: begin
					word <= rd_data;  // Freeze value for both bytes.
					state <= xc_ctrl_pkg::SEND_HI;
				end
				xc_ctrl_pkg::SEND_HI: if (!busy) begin
					lo_sent <= 1'b0;
					state <= xc_ctrl_pkg::WAIT;
				end
				xc_ctrl_pkg::SEND_LO: if (!busy) begin
					lo_sent <= 1'b1;
					state <= xc_ctrl_pkg::WAIT;
				end
				xc_ctrl_pkg::WAIT: if (!busy) begin
					if (!lo_sent) begin
						state <= xc_ctrl_pkg::SEND_LO;
					end else if (idx == idx_w'(`XC_NUM_COUNTERS - 1)) begin
						state <= xc_ctrl_pkg::IDLE;  // Readout done.
					end else begin
						idx <= idx + 1'b1;
						state <= xc_ctrl_pkg::LOAD;
					end
				end
				default: state <= xc_ctrl_pkg::IDLE;
			endcase
		end
	end

	// Start is combinational, so busy is already high in WAIT.
	always_comb begin
		tx_req.start = 1'b0;
		tx_req.data = word[`XC_COUNT_W-1 -: 8];  // High byte.
		if (state == xc_ctrl_pkg::SEND_HI) tx_req.start = !busy;
		if (state == xc_ctrl_pkg::SEND_LO) begin
			tx_req.start = !busy;
			tx_req.data = word[7:0];
		end
	end

	always_comb begin
		ctrl.clear = clear_q;
		ctrl.accumulate = enable && (state == xc_ctrl_pkg::IDLE);  // Drop samples in readout.
		ctrl.rd_index = idx;
	end

endmodule

`default_nettype wire

/* hdl/xc_top.sv */
/*
 * Correlator top with plain ports. All inputs are asynchronous except
 * arst_n. rx and tx are 8N1 at XC_BIT_CLKS clocks per bit.
 */
`timescale 1ns/1ps
`default_nettype none

`include "xc_consts.svh"

module xc_top (
	input  logic                     clki,
	input  logic                     arst_n,
	input  logic [`XC_NUM_LINES-1:0] line_in,
	input  logic                     sample,
	input  logic                     enable,
	input  logic                     rx,
	output logic                     tx
);

	xc_data_pkg::sample_t    smp;      // Sampler to correlator.
	xc_data_pkg::rx_byte_t   rx_byte;  // Receiver to controller.
	xc_data_pkg::count_t     rd_data;  // Selected counter.
	xc_ctrl_pkg::corr_ctrl_t ctrl;
	xc_ctrl_pkg::tx_req_t    tx_req;
	logic                    busy;     // Transmitter stall.

	xc_sampler i_sampler (
		.clki    (clki),
		.arst_n  (arst_n),
		.line_in (line_in),
		.sample  (sample),
		.smp     (smp)
	);

	xc_correlator i_correlator (
		.clki    (clki),
		.arst_n  (arst_n),
		.smp     (smp),
		.ctrl    (ctrl),
		.rd_data (rd_data)
	);

	xc_uart_rx i_uart_rx (
		.clki    (clki),
		.arst_n  (arst_n),
		.rx      (rx),
		.rx_byte (rx_byte)
	);

	xc_uart_tx i_uart_tx (
		.clki   (clki),
		.arst_n (arst_n),
		.req    (tx_req),
		.tx     (tx),
		.busy   (busy)
	);

	xc_control i_control (
		.clki    (clki),
		.arst_n  (arst_n),
		.enable  (enable),
		.rx_byte (rx_byte),
		.busy    (busy),
		.rd_data (rd_data),
		.ctrl    (ctrl),
		.tx_req  (tx_req)
	);

endmodule

`default_nettype wire

/* verif/xc_tb_uart.sv */
/*
 * Serial models for the testbench, 8N1 at XC_BIT_CLKS clocks per bit.
 * The source drives rx a fixed delay after the rising edge. The sink
 * samples tx on falling edges, away from its update edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "xc_consts.svh"

module xc_tb_uart_src (
	input  logic clki,
	output logic rx
);

	localparam int drive_dly = 10;  // After the rising edge.

	initial rx = 1'b1;  // Line idles high.

	// One full frame, returns after the stop bit.
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};  // {stop, data, start}.
		repeat (10) begin
			@(posedge clki);
			#drive_dly rx = bits[0];
			bits = {1'b1, bits[9:1]};
			repeat (`XC_BIT_CLKS - 1) @(posedge clki);
		end
		@(posedge clki);
	endtask

endmodule

module xc_tb_uart_sink (
	input  logic       clki,
	input  logic       tx,
	output logic       got,        // High for one clock per byte.
	output logic [7:0] data,
	output logic       frame_err   // Bad stop bit, valid with got.
);

	logic [7:0] shreg;  // Data bits, LSB first.

	initial begin
		got = 1'b0;
		data = '0;
		frame_err = 1'b0;
		shreg = '0;
	end

	always begin
		@(negedge clki);
		got = 1'b0;
		frame_err = 1'b0;
		if (tx === 1'b0) begin
			repeat (`XC_BIT_CLKS / 2 - 1) @(negedge clki);  // Near start bit center.
			if (tx === 1'b0) begin
				repeat (8) begin
					repeat (`XC_BIT_CLKS) @(negedge clki);
					shreg = {tx, shreg[7:1]};
				end
				repeat (`XC_BIT_CLKS) @(negedge clki);  // Stop bit center.
				frame_err = (tx !== 1'b1);
				data = shreg;
				got = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/xc_tb.sv */
/*
 * Table driven test of the correlator top through its serial link.
 * Saturation needs over 65535 samples and is not exercised here.
 * Random patterns come from $random with seed 19.
 */
`timescale 1ns/1ps
`default_nettype none

`include "xc_consts.svh"

module xc_tb;

	localparam int drive_dly = 10;                         // Input skew after rising edge.
	localparam int num_bytes = 2 * `XC_NUM_COUNTERS;       // Bytes per readout.
	localparam int read_limit = num_bytes * 12 * `XC_BIT_CLKS;  // Frame plus slack.
	localparam int max_cycles = 40000;  // Six readouts, commands, sampling, margin.
	localparam int num_rows = 16;
	localparam logic [1:0] act_sample = 2'd0;  // Fixed pattern, count samples.
	localparam logic [1:0] act_cmd = 2'd1;     // One command byte.
	localparam logic [1:0] act_random = 2'd2;  // Random patterns.
	localparam logic [7:0] cmd_clear = 8'h43;  // 'C'.
	localparam logic [7:0] cmd_read = 8'h52;   // 'R'.

	typedef struct packed {
		logic [1:0] act;
		logic [7:0] arg;    // Line pattern or command byte.
		logic [7:0] count;  // Samples in the row.
		logic       en;     // Enable level.
	} row_t;

	logic                     clki, arst_n, sample, enable, rx, tx;
	logic [`XC_NUM_LINES-1:0] line_in;
	logic                     got, frame_err;
	logic [7:0]               rx_data;
	logic [7:0]               rx_q [$];  // Bytes from the current readout.
	logic [15:0]              model [`XC_NUM_COUNTERS];
	row_t                     rows [num_rows];
	integer                   seed;
	int                       cycles, value_errs, readout_errs, framing_errs, r;

	xc_top i_dut (
		.clki    (clki),
		.arst_n  (arst_n),
		.line_in (line_in),
		.sample  (sample),
		.enable  (enable),
		.rx      (rx),
		.tx      (tx)
	);

	xc_tb_uart_src i_src (.clki(clki), .rx(rx));
	xc_tb_uart_sink i_sink (.clki(clki), .tx(tx), .got(got), .data(rx_data),
		.frame_err(frame_err));

	initial clki = 1'b0;
	always #50 clki = ~clki;  // 100 ns period.

	always @(posedge clki) begin
		if (got) begin
			rx_q.push_back(rx_data);
			if (frame_err) begin
				$display("Framing error on a byte from tx at time %0t", $time);
				framing_errs++;
			end
		end
	end

	// Run limit.
	always @(posedge clki) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", max_cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic drive_edge();
		@(posedge clki);
		#drive_dly;
	endtask

	function automatic row_t make_row(logic [1:0] act, logic [7:0] arg, int count, logic en);
		row_t row;
		row.act = act;
		row.arg = arg;
		row.count = 8'(count);
		row.en = en;
		return row;
	endfunction

	task automatic load_table();
		rows[0] = make_row(act_cmd, cmd_read, 0, 1'b0);     // Zeros after reset.
		rows[1] = make_row(act_sample, 8'h0f, 5, 1'b1);     // All lines.
		rows[2] = make_row(act_sample, 8'h00, 3, 1'b1);     // No line.
		rows[3] = make_row(act_sample, 8'h01, 2, 1'b1);
		rows[4] = make_row(act_sample, 8'h04, 3, 1'b1);
		rows[5] = make_row(act_sample, 8'h0a, 4, 1'b1);
		rows[6] = make_row(act_cmd, cmd_read, 0, 1'b1);
		rows[7] = make_row(act_sample, 8'h0f, 6, 1'b0);     // Enable low, no change.
		rows[8] = make_row(act_cmd, 8'h41, 0, 1'b1);        // Unknown byte.
		rows[9] = make_row(act_cmd, cmd_read, 0, 1'b1);
		rows[10] = make_row(act_cmd, cmd_clear, 0, 1'b1);
		rows[11] = make_row(act_cmd, cmd_read, 0, 1'b1);
		rows[12] = make_row(act_sample, 8'h06, 3, 1'b1);    // Counts from zero.
		rows[13] = make_row(act_cmd, cmd_read, 0, 1'b1);
		rows[14] = make_row(act_random, 8'h00, 60, 1'b1);
		rows[15] = make_row(act_cmd, cmd_read, 0, 1'b1);
	endtask

	// Reference counts, saturating at all ones.
	task automatic model_add(input logic [`XC_NUM_LINES-1:0] pat);
		int p;
		p = `XC_NUM_LINES;  // Pairs follow the auto counts.
		for (int i = 0; i < `XC_NUM_LINES; i++) begin
			if (pat[i] && model[i] != 16'hffff) model[i]++;
			for (int j = i + 1; j < `XC_NUM_LINES; j++) begin
				if (pat[i] && pat[j] && model[p] != 16'hffff) model[p]++;
				p++;
			end
		end
	endtask

	// Two clocks high, six low. Lines held for the whole slot.
	task automatic run_sample(input logic [`XC_NUM_LINES-1:0] pat, input logic en);
		drive_edge();
		line_in = pat;
		sample = 1'b1;
		repeat (2) drive_edge();
		sample = 1'b0;
		repeat (6) drive_edge();
		if (en) model_add(pat);
	endtask

	task automatic check_readout();
		int waited;
		logic [15:0] got_val;
		if (rx_q.size() != 0) begin
			$display("Unexpected bytes on tx before a readout: %0d stray bytes", rx_q.size());
			readout_errs++;
		end
		rx_q.delete();
		i_src.send_byte(cmd_read);
		waited = 0;
		while (rx_q.size() < num_bytes && waited < read_limit) begin
			@(posedge clki);
			waited++;
		end
		repeat (12 * `XC_BIT_CLKS) drive_edge();  // One more frame time, extra bytes show up.
		if (rx_q.size() < num_bytes) begin
			$display("Readout short: received %0d of %0d bytes", rx_q.size(), num_bytes);
			readout_errs++;
		end else if (rx_q.size() > num_bytes) begin
			$display("Readout too long: received %0d bytes", rx_q.size());
			readout_errs++;
		end
		for (int k = 0; k < `XC_NUM_COUNTERS && 2 * k + 1 < rx_q.size(); k++) begin
			got_val = {rx_q[2 * k], rx_q[2 * k + 1]};  // MSB first.
			if (got_val !== model[k]) begin
				$display("Fail at time %0t: counter %0d expected %0d received %0d",
					$time, k, model[k], got_val);
				value_errs++;
			end
		end
		rx_q.delete();
	endtask

	task automatic apply_row(input row_t row);
		logic [31:0] rnd;
		drive_edge();
		enable = row.en;
		if (row.act == act_sample) begin
			for (int n = 0; n < row.count; n++) run_sample(row.arg[`XC_NUM_LINES-1:0], row.en);
		end else if (row.act == act_random) begin
			for (int n = 0; n < row.count; n++) begin
				rnd = $random(seed);
				run_sample(rnd[`XC_NUM_LINES-1:0], row.en);
			end
		end else if (row.arg == cmd_read) begin
			check_readout();
		end else begin
			i_src.send_byte(row.arg);
			if (row.arg == cmd_clear) begin
				for (int k = 0; k < `XC_NUM_COUNTERS; k++) model[k] = '0;
			end
			repeat (12 * `XC_BIT_CLKS) drive_edge();  // Clear lands, a stray frame would too.
		end
	endtask

	initial begin
		line_in = '0;
		sample = 1'b0;
		enable = 1'b0;
		arst_n = 1'b0;
		seed = 19;
		cycles = 0;
		value_errs = 0;
		readout_errs = 0;
		framing_errs = 0;
		for (int k = 0; k < `XC_NUM_COUNTERS; k++) model[k] = '0;
		load_table();
		repeat (5) @(posedge clki);
		#drive_dly arst_n = 1'b1;
		repeat (4) drive_edge();
		if (tx !== 1'b1) begin
			$display("Fail at time %0t: tx is %b after reset, expected idle high", $time, tx);
			value_errs++;
		end
		for (r = 0; r < num_rows; r++) apply_row(rows[r]);
		repeat (10) drive_edge();
		$display("Errors: %0d value, %0d readout, %0d framing",
			value_errs, readout_errs, framing_errs);
		if (value_errs + readout_errs + framing_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hdl/xc_ctrl_pkg.sv
hdl/xc_data_pkg.sv
hdl/xc_sampler.sv
hdl/xc_correlator.sv
hdl/xc_uart_rx.sv
hdl/xc_uart_tx.sv
hdl/xc_control.sv
hdl/xc_top.sv
verif/xc_tb_uart.sv
verif/xc_tb.sv

/* Bender.yml */
package:
  name: xc_correlator

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/xc_ctrl_pkg.sv
      - hdl/xc_data_pkg.sv
      - hdl/xc_sampler.sv
      - hdl/xc_correlator.sv
      - hdl/xc_uart_rx.sv
      - hdl/xc_uart_tx.sv
      - hdl/xc_control.sv
      - hdl/xc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/xc_tb_uart.sv
      - verif/xc_tb.sv
